/* common/csr_pkg.sv */
package csr_pkg;

  localparam int xlen  = 32;
  localparam int cnt_w = 64;

  // machine mode csr addresses
  typedef enum logic [11:0] {
    csr_mstatus   = 12'h300,
    csr_misa      = 12'h301,
    csr_mie       = 12'h304,
    csr_mtvec     = 12'h305,
    csr_mscratch  = 12'h340,
    csr_mepc      = 12'h341,
    csr_mcause    = 12'h342,
    csr_mtval     = 12'h343,
    csr_mip       = 12'h344,
    csr_mcycle    = 12'hb00,
    csr_minstret  = 12'hb02,
    csr_mcycleh   = 12'hb80,
    csr_minstreth = 12'hb82
  } csr_addr_t;

  // synchronous exception codes, mcause bit 31 clear
  typedef enum logic [3:0] {
    exc_misalign_fetch = 4'd0,
    exc_illegal_instr  = 4'd2,
    exc_breakpoint     = 4'd3,
    exc_misalign_load  = 4'd4,
    exc_misalign_store = 4'd6,
    exc_ecall_m        = 4'd11
  } exc_cause_t;

  // interrupt codes, mcause bit 31 set
  typedef enum logic [3:0] {
    irq_msoft  = 4'd3,
    irq_mtimer = 4'd7,
    irq_mext   = 4'd11
  } irq_cause_t;

  // mstatus fields
  localparam int mstatus_mie_bit  = 3;
  localparam int mstatus_mpie_bit = 7;

  // same positions in mie and mip
  localparam int irq_ext_bit = 11;
  localparam int irq_tmr_bit = 7;
  localparam int irq_sw_bit  = 3;

  // sd, tsr..mpp, spp, mpie, spie, upie, mie, sie, uie
  localparam logic [xlen-1:0] mstatus_mask = 32'h807f_f9bb;

  // mxl plus the 26 extension letters
  localparam logic [xlen-1:0] misa_mask = 32'hc3ff_ffff;

  // m, s and u enables for external, timer and software
  localparam logic [xlen-1:0] mie_mask = 32'h0000_0bbb;

  // only s/u pending bits, machine bits come from the pins
  localparam logic [xlen-1:0] mip_sw_mask = 32'h0000_0333;

  // mxl = 1 (rv32), extensions i and m
  localparam logic [xlen-1:0] misa_reset = 32'h4000_1100;

  localparam logic [xlen-1:0] mtvec_reset = 32'h0000_0000;

endpackage

/* csr/csr_trap.sv */
`timescale 1ns/1ns

module csr_trap import csr_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            dec_valid,
  input  logic            dec_exception,
  input  logic [xlen-1:0] dec_epc,
  input  logic [3:0]      dec_ecause,
  input  logic [xlen-1:0] dec_etval,
  input  logic            ex_valid,
  input  logic            ex_exception,
  input  logic [xlen-1:0] ex_epc,
  input  logic [3:0]      ex_ecause,
  input  logic [xlen-1:0] ex_etval,
  input  logic            mem_valid,
  input  logic            mem_exception,
  input  logic [xlen-1:0] mem_epc,
  input  logic [3:0]      mem_ecause,
  input  logic [xlen-1:0] mem_etval,
  input  logic            mstatus_mie,
  input  logic            mie_meie,
  input  logic            mie_mtie,
  input  logic            mie_msie,
  input  logic            mip_meip,
  input  logic            mip_mtip,
  input  logic            mip_msip,
  input  logic [xlen-1:0] mepc,
  output logic            take_trap,
  output logic [xlen-1:0] trap_cause,
  output logic [xlen-1:0] trap_epc,
  output logic [xlen-1:0] trap_tval,
  output logic            trap
);

  logic            irq_ext;
  logic            irq_tmr;
  logic            irq_sw;
  logic [xlen-1:0] irq_epc;

  assign irq_ext = mstatus_mie & mie_meie & mip_meip;
  assign irq_tmr = mstatus_mie & mie_mtie & mip_mtip;
  assign irq_sw  = mstatus_mie & mie_msie & mip_msip;

  // oldest instruction in flight, or keep mepc when the pipe is empty
  always_comb begin
    if (dec_valid) irq_epc = dec_epc;
    else if (ex_valid) irq_epc = ex_epc;
    else if (mem_valid) irq_epc = mem_epc;
    else irq_epc = mepc;
  end

  always_comb begin
    take_trap  = 1'b1;
    trap_cause = '0;
    trap_epc   = irq_epc;
    trap_tval  = '0;
    if (dec_exception) begin
      trap_cause = {28'd0, dec_ecause};
      trap_epc   = dec_epc;
      trap_tval  = dec_etval;
    end else if (ex_exception) begin
      trap_cause = {28'd0, ex_ecause};
      trap_epc   = ex_epc;
      trap_tval  = ex_etval;
    end else if (mem_exception) begin
      trap_cause = {28'd0, mem_ecause};
      trap_epc   = mem_epc;
      trap_tval  = mem_etval;
    end else if (irq_ext) begin
      trap_cause = {1'b1, 27'd0, irq_mext};
    end else if (irq_tmr) begin
      trap_cause = {1'b1, 27'd0, irq_mtimer};
    end else if (irq_sw) begin
      trap_cause = {1'b1, 27'd0, irq_msoft};
    end else begin
      take_trap = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) trap <= 1'b0;
    else trap <= take_trap; // one cycle pulse after the update edge
  end

endmodule

/* csr/csr_counters.sv */
`timescale 1ns/1ns

module csr_counters import csr_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             retire,
  input  logic             wr_en,
  input  logic [11:0]      wr_addr,
  input  logic [xlen-1:0]  wr_data,
  output logic [cnt_w-1:0] mcycle,
  output logic [cnt_w-1:0] minstret
);

  logic wr_cyc_lo;
  logic wr_cyc_hi;
  logic wr_ret_lo;
  logic wr_ret_hi;

  assign wr_cyc_lo = wr_en && (wr_addr == csr_mcycle);
  assign wr_cyc_hi = wr_en && (wr_addr == csr_mcycleh);
  assign wr_ret_lo = wr_en && (wr_addr == csr_minstret);
  assign wr_ret_hi = wr_en && (wr_addr == csr_minstreth);

  always_ff @(posedge clk) begin
    if (!rst) begin
      mcycle   <= '0;
      minstret <= '0;
    end else begin
      // a half write holds off the increment for that cycle
      if (wr_cyc_lo) mcycle[xlen-1:0] <= wr_data;
      else if (wr_cyc_hi) mcycle[cnt_w-1:xlen] <= wr_data;
      else mcycle <= mcycle + cnt_w'(1);

      if (wr_ret_lo) minstret[xlen-1:0] <= wr_data;
      else if (wr_ret_hi) minstret[cnt_w-1:xlen] <= wr_data;
      else if (retire) minstret <= minstret + cnt_w'(1);
    end
  end

endmodule

/* csr/csr_regs.sv */
`timescale 1ns/1ns

module csr_regs import csr_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             rd_en,
  input  logic [11:0]      rd_addr,
  input  logic             wr_en,
  input  logic [11:0]      wr_addr,
  input  logic [xlen-1:0]  wr_data,
  input  logic             dec_mret,
  input  logic             meip,
  input  logic             mtip,
  input  logic             msip,
  input  logic             take_trap,
  input  logic [xlen-1:0]  trap_cause,
  input  logic [xlen-1:0]  trap_epc,
  input  logic [xlen-1:0]  trap_tval,
  input  logic [cnt_w-1:0] mcycle,
  input  logic [cnt_w-1:0] minstret,
  output logic [xlen-1:0]  rd_data,
  output logic             mstatus_mie,
  output logic             mie_meie,
  output logic             mie_mtie,
  output logic             mie_msie,
  output logic             mip_meip,
  output logic             mip_mtip,
  output logic             mip_msip,
  output logic             mret_done,
  output logic [xlen-1:0]  mepc_out,
  output logic [xlen-1:0]  trap_vector
);

  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] misa;
  logic [xlen-1:0] mie;
  logic [xlen-1:0] mip;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mscratch;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mcause;
  logic [xlen-1:0] mtval;

  always_ff @(posedge clk) begin
    if (!rst) begin
      mstatus   <= '0;
      misa      <= misa_reset;
      mie       <= '0;
      mip       <= '0;
      mtvec     <= mtvec_reset;
      mscratch  <= '0;
      mepc      <= '0;
      mcause    <= '0;
      mtval     <= '0;
      mret_done <= 1'b0;
    end else begin
      if (wr_en) begin
        case (wr_addr)
          csr_mstatus:  mstatus <= wr_data & mstatus_mask;
          csr_misa:     misa <= wr_data & misa_mask;
          csr_mie:      mie <= wr_data & mie_mask;
          csr_mip:      mip <= wr_data & mip_sw_mask;
          csr_mtvec:    mtvec <= wr_data;
          csr_mscratch: mscratch <= wr_data;
          csr_mepc:     mepc <= wr_data;
          csr_mcause:   mcause <= wr_data;
          csr_mtval:    mtval <= wr_data;
          default: ;    // counters live in csr_counters
        endcase
      end

      // machine pending bits track the pins
      mip[irq_ext_bit] <= meip;
      mip[irq_tmr_bit] <= mtip;
      mip[irq_sw_bit]  <= msip;

      if (take_trap) begin
        mepc   <= trap_epc;
        mcause <= trap_cause;
        mtval  <= trap_tval;
        mstatus[mstatus_mpie_bit] <= mstatus[mstatus_mie_bit];
        mstatus[mstatus_mie_bit]  <= 1'b0;
      end

      if (dec_mret) begin
        mstatus[mstatus_mie_bit]  <= mstatus[mstatus_mpie_bit];
        mstatus[mstatus_mpie_bit] <= 1'b0;
      end
      mret_done <= dec_mret;
    end
  end

  always_comb begin
    rd_data = '0;
    if (rd_en) begin
      case (rd_addr)
        csr_mstatus:   rd_data = mstatus;
        csr_misa:      rd_data = misa;
        csr_mie:       rd_data = mie;
        csr_mip:       rd_data = mip;
        csr_mtvec:     rd_data = mtvec;
        csr_mscratch:  rd_data = mscratch;
        csr_mepc:      rd_data = mepc;
        csr_mcause:    rd_data = mcause;
        csr_mtval:     rd_data = mtval;
        csr_mcycle:    rd_data = mcycle[xlen-1:0];
        csr_mcycleh:   rd_data = mcycle[cnt_w-1:xlen];
        csr_minstret:  rd_data = minstret[xlen-1:0];
        csr_minstreth: rd_data = minstret[cnt_w-1:xlen];
        default:       rd_data = '0;
      endcase
    end
  end

  assign mstatus_mie = mstatus[mstatus_mie_bit];
  assign mie_meie    = mie[irq_ext_bit];
  assign mie_mtie    = mie[irq_tmr_bit];
  assign mie_msie    = mie[irq_sw_bit];
  assign mip_meip    = mip[irq_ext_bit];
  assign mip_mtip    = mip[irq_tmr_bit];
  assign mip_msip    = mip[irq_sw_bit];
  assign mepc_out    = mepc;

  // vectored mode jumps to base + 4 * cause
  always_comb begin
    if (mtvec[1:0] == 2'b01) trap_vector = {mtvec[xlen-1:2] + {26'd0, mcause[3:0]}, 2'b00};
    else trap_vector = {mtvec[xlen-1:2], 2'b00};
  end

endmodule

/* verilog/csr_unit.sv */
`timescale 1ns/1ns

module csr_unit import csr_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            dec_valid,
  input  logic            dec_exception,
  input  logic [xlen-1:0] dec_epc,
  input  logic [3:0]      dec_ecause,
  input  logic [xlen-1:0] dec_etval,
  input  logic            dec_mret,
  input  logic            rd_en,
  input  logic [11:0]     rd_addr,
  input  logic            ex_valid,
  input  logic            ex_exception,
  input  logic [xlen-1:0] ex_epc,
  input  logic [3:0]      ex_ecause,
  input  logic [xlen-1:0] ex_etval,
  input  logic            wr_en,
  input  logic [11:0]     wr_addr,
  input  logic [xlen-1:0] wr_data,
  input  logic            mem_valid,
  input  logic            mem_exception,
  input  logic [xlen-1:0] mem_epc,
  input  logic [3:0]      mem_ecause,
  input  logic [xlen-1:0] mem_etval,
  input  logic            meip,
  input  logic            mtip,
  input  logic            msip,
  output logic [xlen-1:0] rd_data,
  output logic            trap,
  output logic            mret_done,
  output logic [xlen-1:0] mepc_out,
  output logic [xlen-1:0] trap_vector
);

  logic             mstatus_mie;
  logic             mie_meie;
  logic             mie_mtie;
  logic             mie_msie;
  logic             mip_meip;
  logic             mip_mtip;
  logic             mip_msip;
  logic             take_trap;
  logic [xlen-1:0]  trap_cause;
  logic [xlen-1:0]  trap_epc;
  logic [xlen-1:0]  trap_tval;
  logic [cnt_w-1:0] mcycle;
  logic [cnt_w-1:0] minstret;

  csr_trap csr_trap_i (
    .clk, .rst,
    .dec_valid, .dec_exception, .dec_epc, .dec_ecause, .dec_etval,
    .ex_valid, .ex_exception, .ex_epc, .ex_ecause, .ex_etval,
    .mem_valid, .mem_exception, .mem_epc, .mem_ecause, .mem_etval,
    .mstatus_mie, .mie_meie, .mie_mtie, .mie_msie,
    .mip_meip, .mip_mtip, .mip_msip,
    .mepc       (mepc_out),
    .take_trap, .trap_cause, .trap_epc, .trap_tval, .trap
  );

  csr_counters csr_counters_i (
    .clk, .rst,
    .retire     (ex_valid), // every valid execute slot retires
    .wr_en, .wr_addr, .wr_data,
    .mcycle, .minstret
  );

  csr_regs csr_regs_i (
    .clk, .rst, .rd_en, .rd_addr, .wr_en, .wr_addr, .wr_data,
    .dec_mret, .meip, .mtip, .msip,
    .take_trap, .trap_cause, .trap_epc, .trap_tval,
    .mcycle, .minstret, .rd_data,
    .mstatus_mie, .mie_meie, .mie_mtie, .mie_msie,
    .mip_meip, .mip_mtip, .mip_msip,
    .mret_done, .mepc_out, .trap_vector
  );

endmodule

/* verif/csr_unit_tb.sv */
`timescale 1ns/1ns

module csr_unit_tb import csr_pkg::*; ();

  logic            clk;
  logic            rst;
  logic            dec_valid, dec_exception, dec_mret;
  logic            ex_valid, ex_exception;
  logic            mem_valid, mem_exception;
  logic            rd_en, wr_en;
  logic            meip, mtip, msip;
  logic [3:0]      dec_ecause, ex_ecause, mem_ecause;
  logic [11:0]     rd_addr, wr_addr;
  logic [xlen-1:0] dec_epc, dec_etval;
  logic [xlen-1:0] ex_epc, ex_etval;
  logic [xlen-1:0] mem_epc, mem_etval;
  logic [xlen-1:0] wr_data;
  logic [xlen-1:0] rd_data;
  logic            trap;
  logic            mret_done;
  logic [xlen-1:0] mepc_out;
  logic [xlen-1:0] trap_vector;

  logic [31:0] stim [0:255]; // four words per operation
  logic [31:0] rng_state;

  csr_unit csr_unit_i (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check(input string what, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s: got %08h, expected %08h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // polls on falling edges, gives up after 20 cycles
  task automatic wait_pulse(input string what);
    int   n;
    logic seen;
    n = 0;
    seen = (what == "trap") ? trap : mret_done;
    while (!seen && n < 20) begin
      @(negedge clk);
      n++;
      seen = (what == "trap") ? trap : mret_done;
    end
    if (!seen) begin
      $display("%s pulse never came within 20 cycles", what);
      $display("Test failed");
      $fatal(1, "pulse timeout");
    end
  endtask

  task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
    @(negedge clk);
    wr_en = 1'b0;
  endtask

  task automatic read_csr(input logic [11:0] addr, input logic [31:0] expected);
    csr_addr_t a;
    string     name;
    a = csr_addr_t'(addr);
    name = a.name();
    if (name == "") name = "unknown csr";
    rd_en   = 1'b1;
    rd_addr = addr;
    #1; // combinational read settles inside the low phase
    check(name, rd_data, expected);
    @(negedge clk);
    rd_en = 1'b0;
  endtask

  // mask bit 0 decode, bit 1 execute, bit 2 memory
  task automatic raise_exceptions(input logic [2:0] mask, input logic [31:0] base,
                                  input logic [31:0] epc_exp);
    dec_exception = mask[0];
    ex_exception  = mask[1];
    mem_exception = mask[2];
    dec_epc    = base;
    ex_epc     = base + 32'd4;
    mem_epc    = base + 32'd8;
    dec_etval  = ~dec_epc;
    ex_etval   = ~ex_epc;
    mem_etval  = ~mem_epc;
    dec_ecause = exc_illegal_instr;
    ex_ecause  = exc_ecall_m;
    mem_ecause = exc_misalign_store;
    @(negedge clk);
    {dec_exception, ex_exception, mem_exception} = '0;
    wait_pulse("trap");
    check("mepc_out", mepc_out, epc_exp);
  endtask

  task automatic do_mret();
    dec_mret = 1'b1;
    @(negedge clk);
    dec_mret = 1'b0;
    wait_pulse("mret_done");
  endtask

  task automatic retire(input logic [31:0] count);
    ex_valid = 1'b1;
    repeat (count) @(negedge clk);
    ex_valid = 1'b0;
  endtask

  // en bit 2 external, bit 1 timer, bit 0 software
  task automatic run_irqs(input logic [2:0] en, input logic [31:0] tvec,
                          input logic [31:0] count);
    logic [2:0]  pins;
    logic [2:0]  pend;
    logic [2:0]  valid;
    logic [3:0]  code;
    logic [31:0] vec_exp;
    logic [31:0] epc_exp;
    epc_exp = 32'h0000_0100;
    write_csr(csr_mepc, epc_exp); // known mepc for traps with an empty pipe
    write_csr(csr_mie, {20'd0, en[2], 3'd0, en[1], 3'd0, en[0], 3'd0});
    write_csr(csr_mtvec, tvec);
    repeat (count) begin
      rng_state = xorshift(rng_state);
      pins = rng_state[10:8];
      valid = rng_state[18:16]; // bit 0 decode, bit 1 execute, bit 2 memory
      pend = pins & en;
      meip = pins[2];
      mtip = pins[1];
      msip = pins[0];
      write_csr(csr_mstatus, 32'h0000_0008); // global mie on
      {meip, mtip, msip} = '0;
      {mem_valid, ex_valid, dec_valid} = valid;
      dec_epc = {rng_state[31:2], 2'b00};
      ex_epc  = dec_epc + 32'd4;
      mem_epc = dec_epc + 32'd8;
      if (pend != 3'b000) begin
        if (pend[2]) code = irq_mext;
        else if (pend[1]) code = irq_mtimer;
        else code = irq_msoft;
        if (tvec[1:0] == 2'b01) vec_exp = {tvec[31:2], 2'b00} + {26'd0, code, 2'b00};
        else vec_exp = {tvec[31:2], 2'b00};
        // the oldest valid stage gives the epc
        if (valid[0]) epc_exp = dec_epc;
        else if (valid[1]) epc_exp = ex_epc;
        else if (valid[2]) epc_exp = mem_epc;
        wait_pulse("trap");
        check("trap_vector", trap_vector, vec_exp);
        check("mepc_out", mepc_out, epc_exp);
        read_csr(csr_mcause, {1'b1, 27'd0, code});
        read_csr(csr_mtval, 32'd0);
      end else begin
        repeat (3) begin
          @(negedge clk);
          check("trap", {31'd0, trap}, 32'd0);
        end
      end
      {dec_valid, ex_valid, mem_valid} = '0;
    end
  endtask

  initial begin
    logic [7:0]  p;
    logic [31:0] op;
    logic [31:0] arg;
    logic [31:0] data;
    logic [31:0] expected;
    int          n;
    clk = 1'b0;
    rst = 1'b0;
    {dec_valid, dec_exception, dec_mret, ex_valid, ex_exception} = '0;
    {mem_valid, mem_exception, rd_en, wr_en, meip, mtip, msip} = '0;
    {dec_ecause, ex_ecause, mem_ecause, rd_addr, wr_addr} = '0;
    {dec_epc, dec_etval, ex_epc, ex_etval, mem_epc, mem_etval, wr_data} = '0;
    rng_state = 32'd98;
    op = 32'd0;
    $readmemh("verif/csr_stim.txt", stim);
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    p = 8'd0;
    for (n = 0; n < 64; n++) begin
      op       = stim[p];
      arg      = stim[p + 8'd1];
      data     = stim[p + 8'd2];
      expected = stim[p + 8'd3];
      if (op === 32'hf) break;
      case (op)
        32'h0: begin
          #1; // read port is gated off while rd_en is low
          check("idle rd_data", rd_data, 32'd0);
          repeat (data) @(negedge clk);
        end
        32'h1: write_csr(arg[11:0], data);
        32'h2: read_csr(arg[11:0], expected);
        32'h3: raise_exceptions(arg[2:0], data, expected);
        32'h4: run_irqs(arg[2:0], data, expected);
        32'h5: do_mret();
        32'h6: retire(data);
        default: begin
          $display("stim file holds an unknown op %h at entry %0d", op, n);
          $display("Test failed");
          $fatal(1, "bad stimulus");
        end
      endcase
      p = p + 8'd4;
    end
    if (op !== 32'hf) begin
      $display("stim file ended without its end marker");
      $display("Test failed");
      $fatal(1, "bad stimulus");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

/* verif/csr_stim.txt */
// op addr data expected, all hex, one operation per line
// op 0 idle, 1 write, 2 read, 3 exception (addr is stage mask), 4 irq, 5 mret, 6 retire, f end
2 301 00000000 40001100 // misa reset value
2 305 00000000 00000000
2 7c0 00000000 00000000 // not a csr
1 300 ffffffff 00000000
2 300 00000000 807ff9bb
1 304 ffffffff 00000000
2 304 00000000 00000bbb
1 344 ffffffff 00000000
2 344 00000000 00000333 // pins low
1 340 a5a5c3c3 00000000
2 340 00000000 a5a5c3c3
1 305 00000101 00000000
2 305 00000000 00000101
1 300 00000008 00000000 // mie set, mpie clear
3 006 00001000 00001004 // execute beats memory
2 342 00000000 0000000b
2 343 00000000 ffffeffb
2 300 00000000 00000080
5 000 00000000 00000000
2 300 00000000 00000008
3 007 00002000 00002000 // decode wins
2 342 00000000 00000002
2 343 00000000 ffffdfff
5 000 00000000 00000000
3 004 00003000 00003008
2 342 00000000 00000006
2 341 00000000 00003008
1 b80 00000005 00000000
1 b00 fffffffe 00000000
0 000 00000004 00000000
2 b00 00000000 00000002 // write edge plus four idle cycles, carries into the high half
2 b80 00000000 00000006
1 b02 00000020 00000000
2 b02 00000000 00000020
6 000 00000005 00000000
2 b02 00000000 00000025
4 007 00000201 00000008 // all enables, vectored base 200
4 005 00000300 00000008 // external and software, direct
4 002 00000401 00000006 // timer only, vectored
f 000 00000000 00000000

/* files.f */
common/csr_pkg.sv
csr/csr_trap.sv
csr/csr_counters.sv
csr/csr_regs.sv
verilog/csr_unit.sv
verif/csr_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the csr unit testbench with verilator and run it

verilator --binary --timescale 1ns/1ns --top-module csr_unit_tb -f files.f -o csr_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/csr_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test completed successfully" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
